// ==== Makefile ====
# Verilator build and run for the reorder buffer testbench
# any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed
SIM       ?= $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/rob_tb.sv ====
module rob_tb;

  import rob_pkg::*;

  // one dispatched group as the model sees it
  typedef struct packed {
    logic [CMT_ID_W-1:0]     id;
    logic [PC_W-1:0]         pc;
    logic [DISP_SIZE-1:0]    mask;
    logic [DISP_SIZE-1:0]    exc;
    logic [DISP_SIZE-1:0]    mispred;
    except_t [DISP_SIZE-1:0] etype;
  } grp_t;

  localparam int WAIT_LIMIT = 200;   // cycles per wait loop

  logic                 clk;
  logic                 reset_n;
  disp_t                disp;
  done_rpt_t            done_rpt [CMT_BUS_SIZE];
  logic [CMT_ID_W-1:0]  cmt_id;
  commit_blk_t          cmt_blk;
  logic                 credit_return;

  grp_t                 model_q [$];        // dispatched, not yet committed
  grp_t                 slot_grp [ENTRY_NUM];
  logic [DISP_SIZE-1:0] pend [ENTRY_NUM];   // lanes still to report
  int                   credits;
  int                   disp_count;
  int                   commit_count;
  int                   return_count;
  int                   value_errs;
  int                   credit_errs;
  int                   timeout_errs;
  logic [31:0]          rng_state;
  string                test_name;

  rob_top uut (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_disp          (disp),
    .i_done_rpt      (done_rpt),
    .o_cmt_id        (cmt_id),
    .o_commit        (cmt_blk),
    .o_credit_return (credit_return)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // credit timing
  // --------------------------------------------------
  credit_follows_commit: assert property (@(posedge clk) disable iff (!reset_n)
      cmt_blk.commit |=> credit_return)
    else begin
      credit_errs++;
      $display("%s: no credit return in the cycle after a commit", test_name);
    end

  credit_only_after_commit: assert property (@(posedge clk) disable iff (!reset_n)
      !cmt_blk.commit |=> !credit_return)
    else begin
      credit_errs++;
      $display("%s: credit returned without a commit the cycle before", test_name);
    end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 8;
  endfunction

  function automatic void check_value(input string field, input logic [31:0] exp_v,
                                      input logic [31:0] act_v);
    assert (act_v == exp_v) else begin
      value_errs++;
      $display("ERR %s %s: expected %0h actual %0h", test_name, field, exp_v, act_v);
    end
  endfunction

  function automatic logic [DISP_SIZE-1:0] random_mask();
    return 4'(next_rand() % 15 + 1);   // never empty
  endfunction

  function automatic except_t random_exc();
    return except_t'(3'(next_rand() % 5 + 1));
  endfunction

  function automatic grp_t plain_group(input logic [DISP_SIZE-1:0] mask);
    grp_t g;
    g      = '0;
    g.mask = mask;
    return g;
  endfunction

  function automatic int pending_lanes();
    int n;
    n = 0;
    for (int s = 0; s < ENTRY_NUM; s++) begin
      n += $countones(pend[s]);
    end
    return n;
  endfunction

  // --------------------------------------------------
  // commit monitor, sampled mid cycle
  // --------------------------------------------------
  always @(negedge clk) begin
    grp_t                 g;
    logic [DISP_SIZE-1:0] flag;
    logic [DISP_SIZE-1:0] dead;
    logic [DISP_SIZE-1:0] exp_ev;
    except_t              exp_type;
    int                   first;
    if (reset_n && cmt_blk.commit) begin
      commit_count++;
      assert (model_q.size() > 0) else begin
        value_errs++;
        $display("%s: commit seen with no group outstanding", test_name);
      end
      if (model_q.size() > 0) begin
        g     = model_q.pop_front();
        flag  = (g.exc | g.mispred) & g.mask;
        first = -1;
        dead  = '0;
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (first >= 0) begin
            dead[d] = g.mask[d];   // younger than the flagged lane
          end else if (flag[d]) begin
            first = d;
          end
        end
        exp_ev   = '0;
        exp_type = EXC_NONE;
        if (first >= 0) begin
          if (g.exc[first]) begin
            exp_ev[first] = 1'b1;
            exp_type      = g.etype[first];
          end
        end
        assert (pend[g.id[ENTRY_W-1:0]] == '0) else begin
          value_errs++;
          $display("%s: group committed with lanes still unreported", test_name);
        end
        check_value("cmt_id", 32'(g.id), 32'(cmt_blk.cmt_id));
        check_value("grp_id", 32'(g.mask), 32'(cmt_blk.grp_id));
        check_value("dead_id", 32'(dead), 32'(cmt_blk.dead_id));
        check_value("except_valid", 32'(exp_ev), 32'(cmt_blk.except_valid));
        check_value("except_type", 32'(exp_type), 32'(cmt_blk.except_type));
        if (exp_ev != '0) begin
          check_value("epc", g.pc + 32'(first * 4), cmt_blk.epc);
        end
      end
    end
    if (reset_n && credit_return) begin
      credits++;
      return_count++;
      assert (credits <= ENTRY_NUM) else begin
        credit_errs++;
        $display("%s: more credits returned than were taken", test_name);
      end
    end
  end

  // --------------------------------------------------
  // stimulus, every task starts and ends 1 after posedge
  // --------------------------------------------------
  task automatic dispatch_group(input grp_t g_in);
    grp_t g;
    int   t;
    g = g_in;
    t = 0;
    while (credits == 0 && t < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (credits == 0) begin
      timeout_errs++;
      $display("%s: timed out waiting for a dispatch credit", test_name);
    end else begin
      g.id = disp_count[CMT_ID_W-1:0];
      g.pc = 32'h8000_0000 + 32'(disp_count * 16);
      disp.valid   = 1'b1;
      disp.pc_addr = g.pc;
      disp.grp_id  = g.mask;
      slot_grp[g.id[ENTRY_W-1:0]] = g;
      pend[g.id[ENTRY_W-1:0]]     = g.mask;
      model_q.push_back(g);
      credits--;
      disp_count++;
      @(posedge clk);
      #1;
      disp.valid = 1'b0;
      check_value("o_cmt_id", 32'(disp_count % 16), 32'(cmt_id));
    end
  endtask

  task automatic drive_report(input int b, input int s, input int d);
    done_rpt[b].valid        = 1'b1;
    done_rpt[b].cmt_id       = slot_grp[s].id;
    done_rpt[b].grp_id       = '0;
    done_rpt[b].grp_id[d]    = 1'b1;
    done_rpt[b].except_valid = slot_grp[s].exc[d];
    done_rpt[b].except_type  = slot_grp[s].etype[d];
    done_rpt[b].mispred      = slot_grp[s].mispred[d];
    pend[s][d] = 1'b0;
  endtask

  task automatic clear_reports();
    for (int b = 0; b < CMT_BUS_SIZE; b++) begin
      done_rpt[b] = '0;
    end
  endtask

  // random lane order across all entries, one lane per bus per cycle
  task automatic report_all();
    int cand [$];
    int pick;
    int t;
    t = 0;
    while (pending_lanes() > 0 && t < WAIT_LIMIT) begin
      cand.delete();
      for (int s = 0; s < ENTRY_NUM; s++) begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (pend[s][d]) begin
            cand.push_back(s * DISP_SIZE + d);
          end
        end
      end
      for (int b = 0; b < CMT_BUS_SIZE; b++) begin
        if (cand.size() > 0) begin
          pick = int'(next_rand() % cand.size());
          drive_report(b, cand[pick] / DISP_SIZE, cand[pick] % DISP_SIZE);
          cand.delete(pick);
        end
      end
      @(posedge clk);
      #1;
      clear_reports();
      t++;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((model_q.size() != 0 || credits != ENTRY_NUM) && t < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (model_q.size() != 0 || credits != ENTRY_NUM) begin
      timeout_errs++;
      $display("%s: timed out waiting for the buffer to drain", test_name);
    end
  endtask

  initial begin
    grp_t g;
    int   lane;
    int   hi;
    int   seen;
    int   s;
    clk          = 1'b0;
    reset_n      = 1'b0;
    disp         = '0;
    clear_reports();
    rng_state    = 32'd92;
    credits      = ENTRY_NUM;
    disp_count   = 0;
    commit_count = 0;
    return_count = 0;
    value_errs   = 0;
    credit_errs  = 0;
    timeout_errs = 0;
    for (int e = 0; e < ENTRY_NUM; e++) begin
      pend[e] = '0;
    end
    test_name = "reset";
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;
    for (int c = 0; c < 4; c++) begin
      check_value("o_cmt_id", 32'd0, 32'(cmt_id));
      check_value("commit", 32'd0, 32'(cmt_blk.commit));
      check_value("credit_return", 32'd0, 32'(credit_return));
      @(posedge clk);
      #1;
    end

    test_name = "in_order";
    for (int n = 0; n < 6; n++) begin
      dispatch_group(plain_group(random_mask()));
    end
    report_all();
    wait_drain();

    test_name = "gating";
    dispatch_group(plain_group(4'b1111));
    s    = (disp_count - 1) % ENTRY_NUM;
    lane = int'(next_rand() % 4);
    pend[s][lane] = 1'b0;   // hold one lane back
    report_all();
    pend[s][lane] = 1'b1;
    seen = commit_count;
    for (int c = 0; c < 6; c++) begin
      @(posedge clk);
      #1;
    end
    check_value("early_commits", 32'(seen), 32'(commit_count));
    drive_report(0, s, lane);
    @(posedge clk);
    #1;
    clear_reports();
    wait_drain();

    test_name = "mispredict";
    for (int n = 0; n < 2; n++) begin
      lane            = int'(next_rand() % 4);
      g               = plain_group(random_mask());
      g.mask[lane]    = 1'b1;
      g.mispred[lane] = 1'b1;
      dispatch_group(g);
    end
    report_all();
    wait_drain();

    test_name = "exception";
    for (int n = 0; n < 3; n++) begin
      lane          = int'(next_rand() % 4);
      g             = plain_group(random_mask());
      g.mask[lane]  = 1'b1;
      g.exc[lane]   = 1'b1;
      g.etype[lane] = random_exc();
      if (lane < DISP_SIZE - 1) begin
        hi         = lane + 1 + int'(next_rand() % (DISP_SIZE - 1 - lane));
        g.mask[hi] = 1'b1;
        if (next_rand() % 2 == 0) begin
          g.mispred[hi] = 1'b1;
        end else begin
          g.exc[hi]   = 1'b1;   // younger fault, must be masked
          g.etype[hi] = random_exc();
        end
      end
      dispatch_group(g);
    end
    report_all();
    wait_drain();

    test_name = "credits";
    while (credits > 0) begin
      dispatch_group(plain_group(random_mask()));
    end
    check_value("outstanding", 32'(ENTRY_NUM), 32'(model_q.size()));
    report_all();
    wait_drain();
    check_value("credits", 32'(ENTRY_NUM), 32'(credits));
    check_value("credit_returns", 32'(commit_count), 32'(return_count));
    check_value("commits", 32'(disp_count), 32'(commit_count));

    $display("errors: value %0d, credit %0d, timeout %0d; commits %0d, credits returned %0d",
             value_errs, credit_errs, timeout_errs, commit_count, return_count);
    if (value_errs + credit_errs + timeout_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/rob_alloc.sv ====
module rob_alloc (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  rob_pkg::disp_t                   i_disp,

  output logic [rob_pkg::ENTRY_NUM-1:0]    o_load_oh,
  output rob_pkg::rob_entry_t              o_load_entry,
  output logic [rob_pkg::CMT_ID_W-1:0]     o_cmt_id
);

  import rob_pkg::*;

  logic [CMT_ID_W-1:0] r_cmt_id;   // tail, next id to hand out
  logic [ENTRY_W-1:0]  w_tail_idx;

  assign w_tail_idx = r_cmt_id[ENTRY_W-1:0];

  // --------------------------------------------------
  // tail pointer
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_cmt_id <= '0;
    end else if (i_disp.valid) begin
      r_cmt_id <= r_cmt_id + 1'b1;   // wrap bit flips every ENTRY_NUM groups
    end
  end

  assign o_cmt_id = r_cmt_id;

  // load strobe to the tail entry only
  always_comb begin
    o_load_oh = '0;
    if (i_disp.valid) begin
      o_load_oh[w_tail_idx] = 1'b1;
    end
  end

  // fresh entry image, nothing reported yet
  always_comb begin
    o_load_entry.state        = ENTRY_WAIT;
    o_load_entry.cmt_id       = r_cmt_id;
    o_load_entry.pc_addr      = i_disp.pc_addr;
    o_load_entry.grp_id       = i_disp.grp_id;
    o_load_entry.done_grp_id  = '0;
    o_load_entry.except_valid = '0;
    o_load_entry.mispred      = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_load_entry.except_type[d] = EXC_NONE;
    end
  end

endmodule

// ==== verilog/rob_commit.sv ====
module rob_commit (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  rob_pkg::rob_entry_t              i_entries [rob_pkg::ENTRY_NUM],

  output logic [rob_pkg::ENTRY_NUM-1:0]    o_commit_finish,
  output rob_pkg::commit_blk_t             o_commit,
  output logic                             o_credit_return
);

  import rob_pkg::*;

  logic [CMT_ID_W-1:0]          r_head_id;
  logic [ENTRY_W-1:0]           w_head_idx;
  rob_entry_t                   w_head;
  logic                         w_commit;

  logic [DISP_SIZE-1:0]         w_flag;      // mispredict or exception lanes
  logic [DISP_SIZE-1:0]         w_first_oh;  // lowest flagged lane
  logic [$clog2(DISP_SIZE)-1:0] w_first_idx;
  logic [DISP_SIZE-1:0]         w_above;     // lanes after the first flag
  logic                         w_found;
  logic [DISP_SIZE-1:0]         w_except_oh;

  logic                         r_credit_return;

  // --------------------------------------------------
  // head pointer
  // --------------------------------------------------
  assign w_head_idx = r_head_id[ENTRY_W-1:0];
  assign w_head     = i_entries[w_head_idx];
  assign w_commit   = (w_head.state == ENTRY_DONE);

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_head_id <= '0;
    end else if (w_commit) begin
      r_head_id <= r_head_id + 1'b1;
    end
  end

  // free the head entry at the next edge
  always_comb begin
    o_commit_finish = '0;
    if (w_commit) begin
      o_commit_finish[w_head_idx] = 1'b1;
    end
  end

  // --------------------------------------------------
  // head group analysis
  // --------------------------------------------------
  assign w_flag = (w_head.except_valid | w_head.mispred) & w_head.grp_id;

  // scan from lane 0, everything past the first flag is dead
  always_comb begin
    w_first_oh  = '0;
    w_first_idx = '0;
    w_above     = '0;
    w_found     = 1'b0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_found) begin
        w_above[d] = 1'b1;
      end else if (w_flag[d]) begin
        w_found       = 1'b1;
        w_first_oh[d] = 1'b1;
        w_first_idx   = d[$clog2(DISP_SIZE)-1:0];
      end
    end
  end

  // a mispredict on the first flagged lane masks later exceptions
  assign w_except_oh = w_first_oh & w_head.except_valid;

  // --------------------------------------------------
  // commit block
  // --------------------------------------------------
  always_comb begin
    o_commit.commit       = w_commit;
    o_commit.cmt_id       = r_head_id;
    o_commit.grp_id       = w_head.grp_id;
    o_commit.except_valid = w_except_oh;
    o_commit.except_type  = (|w_except_oh) ? w_head.except_type[w_first_idx] : EXC_NONE;
    o_commit.epc          = w_head.pc_addr + PC_W'({w_first_idx, 2'b00});  // 4 bytes per lane
    o_commit.dead_id      = w_above & w_head.grp_id;
  end

  // --------------------------------------------------
  // credit return
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_credit_return <= 1'b0;
    end else begin
      r_credit_return <= w_commit;   // one credit per committed entry
    end
  end

  assign o_credit_return = r_credit_return;

endmodule

// ==== verilog/rob_entry.sv ====
module rob_entry (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // load from allocator
  input  logic                   i_load_valid,
  input  rob_pkg::rob_entry_t    i_load_entry,

  // completion reports
  input  rob_pkg::done_rpt_t     i_done_rpt [rob_pkg::CMT_BUS_SIZE],

  // release from commit stage
  input  logic                   i_commit_finish,

  output rob_pkg::rob_entry_t    o_entry
);

  import rob_pkg::*;

  rob_entry_t              r_entry;

  logic [CMT_BUS_SIZE-1:0] w_rpt_hit;
  logic [DISP_SIZE-1:0]    w_done_set;
  logic [DISP_SIZE-1:0]    w_except_set;
  logic [DISP_SIZE-1:0]    w_mispred_set;
  logic [DISP_SIZE-1:0]    w_done_next;
  except_t [DISP_SIZE-1:0] w_except_type_next;

  // --------------------------------------------------
  // report merge
  // --------------------------------------------------
  always_comb begin
    for (int b = 0; b < CMT_BUS_SIZE; b++) begin
      w_rpt_hit[b] = i_done_rpt[b].valid &
                     (i_done_rpt[b].cmt_id == r_entry.cmt_id) &
                     (r_entry.state == ENTRY_WAIT);
    end
  end

  always_comb begin
    w_done_set         = '0;
    w_except_set       = '0;
    w_mispred_set      = '0;
    w_except_type_next = r_entry.except_type;
    for (int b = 0; b < CMT_BUS_SIZE; b++) begin
      if (w_rpt_hit[b]) begin
        w_done_set = w_done_set | i_done_rpt[b].grp_id;
        if (i_done_rpt[b].except_valid) begin
          w_except_set = w_except_set | i_done_rpt[b].grp_id;
          for (int d = 0; d < DISP_SIZE; d++) begin
            if (i_done_rpt[b].grp_id[d]) begin
              w_except_type_next[d] = i_done_rpt[b].except_type;
            end
          end
        end
        if (i_done_rpt[b].mispred) begin
          w_mispred_set = w_mispred_set | i_done_rpt[b].grp_id;
        end
      end
    end
  end

  assign w_done_next = r_entry.done_grp_id | w_done_set;

  // --------------------------------------------------
  // entry FSM
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_entry.state <= ENTRY_FREE;
    end else begin
      case (r_entry.state)
        ENTRY_FREE: begin
          if (i_load_valid) begin
            r_entry <= i_load_entry;   // image arrives with state WAIT
          end
        end
        ENTRY_WAIT: begin
          r_entry.done_grp_id  <= w_done_next;
          r_entry.except_valid <= r_entry.except_valid | w_except_set;
          r_entry.except_type  <= w_except_type_next;
          r_entry.mispred      <= r_entry.mispred | w_mispred_set;
          if (w_done_next == r_entry.grp_id) begin
            r_entry.state <= ENTRY_DONE;   // last lane in
          end
        end
        ENTRY_DONE: begin
          if (i_commit_finish) begin
            r_entry.state <= ENTRY_FREE;
          end
        end
        default: r_entry.state <= ENTRY_FREE;
      endcase
    end
  end

  assign o_entry = r_entry;

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int DISP_SIZE    = 4;   // lanes per dispatch group
  localparam int ENTRY_NUM    = 8;   // buffer depth
  localparam int ENTRY_W      = 3;   // entry index
  localparam int CMT_ID_W     = 4;   // entry index plus wrap bit
  localparam int CMT_BUS_SIZE = 2;   // completion report buses
  localparam int PC_W         = 32;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  typedef enum logic [2:0] {
    EXC_NONE         = 3'd0,
    EXC_ILLEGAL_INST = 3'd1,
    EXC_BREAKPOINT   = 3'd2,
    EXC_ECALL        = 3'd3,
    EXC_LOAD_FAULT   = 3'd4,
    EXC_STORE_FAULT  = 3'd5
  } except_t;

  // entry life cycle, free -> wait -> done -> free
  typedef enum logic [1:0] {
    ENTRY_FREE = 2'd0,
    ENTRY_WAIT = 2'd1,
    ENTRY_DONE = 2'd2
  } entry_state_t;

  // --------------------------------------------------
  // bundles
  // --------------------------------------------------
  typedef struct packed {
    logic                 valid;
    logic [PC_W-1:0]      pc_addr;   // pc of lane 0
    logic [DISP_SIZE-1:0] grp_id;    // lane valid mask
  } disp_t;

  typedef struct packed {
    logic                 valid;
    logic [CMT_ID_W-1:0]  cmt_id;
    logic [DISP_SIZE-1:0] grp_id;    // one-hot lane
    logic                 except_valid;
    except_t              except_type;
    logic                 mispred;
  } done_rpt_t;

  typedef struct packed {
    entry_state_t                state;
    logic [CMT_ID_W-1:0]         cmt_id;
    logic [PC_W-1:0]             pc_addr;
    logic [DISP_SIZE-1:0]        grp_id;
    logic [DISP_SIZE-1:0]        done_grp_id;   // lanes reported so far
    logic [DISP_SIZE-1:0]        except_valid;
    except_t [DISP_SIZE-1:0]     except_type;
    logic [DISP_SIZE-1:0]        mispred;
  } rob_entry_t;

  typedef struct packed {
    logic                 commit;
    logic [CMT_ID_W-1:0]  cmt_id;
    logic [DISP_SIZE-1:0] grp_id;
    logic [DISP_SIZE-1:0] except_valid;   // one-hot
    except_t              except_type;
    logic [PC_W-1:0]      epc;
    logic [DISP_SIZE-1:0] dead_id;        // lanes squashed at commit
  } commit_blk_t;

endpackage

// ==== verilog/rob_top.sv ====
module rob_top (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  // dispatch, gated by credits only
  input  rob_pkg::disp_t                 i_disp,

  // execution completion
  input  rob_pkg::done_rpt_t             i_done_rpt [rob_pkg::CMT_BUS_SIZE],

  output logic [rob_pkg::CMT_ID_W-1:0]   o_cmt_id,
  output rob_pkg::commit_blk_t           o_commit,
  output logic                           o_credit_return
);

  import rob_pkg::*;

  logic [ENTRY_NUM-1:0] w_load_oh;
  rob_entry_t           w_load_entry;
  rob_entry_t           w_entries [ENTRY_NUM];
  logic [ENTRY_NUM-1:0] w_commit_finish;

  rob_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .o_load_oh    (w_load_oh),
    .o_load_entry (w_load_entry),
    .o_cmt_id     (o_cmt_id)
  );

  // --------------------------------------------------
  // entries
  // --------------------------------------------------
  generate
    for (genvar e = 0; e < ENTRY_NUM; e++) begin : entry_loop
      rob_entry u_entry (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_load_valid    (w_load_oh[e]),
        .i_load_entry    (w_load_entry),
        .i_done_rpt      (i_done_rpt),
        .i_commit_finish (w_commit_finish[e]),
        .o_entry         (w_entries[e])
      );
    end
  endgenerate

  rob_commit u_commit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_entries       (w_entries),
    .o_commit_finish (w_commit_finish),
    .o_commit        (o_commit),
    .o_credit_return (o_credit_return)
  );

endmodule

// ==== vlog.f ====
verilog/rob_pkg.sv
verilog/rob_alloc.sv
verilog/rob_entry.sv
verilog/rob_commit.sv
verilog/rob_top.sv
verification/rob_tb.sv
